//--- csr_pkg.sv
package csr_pkg;

    //////////////////////////////////////////////////
    // widths and constants
    //////////////////////////////////////////////////

    localparam int XLEN         = 64;
    localparam int CSR_IDX_W    = 12;
    localparam int OPCODE_W     = 7;
    localparam int TRAP_CAUSE_W = 6;

    // rv64 (mxl = 2) with the i and m extensions
    localparam logic [XLEN-1:0] MISA_VALUE      = 64'h8000_0000_0000_1100;
    localparam logic [XLEN-1:0] MHARTID_VALUE   = '0;
    localparam logic [XLEN-1:0] MVENDORID_VALUE = '0;
    localparam logic [XLEN-1:0] MARCHID_VALUE   = '0;
    localparam logic [XLEN-1:0] MIMPID_VALUE    = '0;

    // mstatus fields
    localparam int         MSTATUS_MIE_BIT  = 3;
    localparam int         MSTATUS_MPIE_BIT = 7;
    localparam int         MSTATUS_MPP_LSB  = 11;
    localparam logic [1:0] MSTATUS_MPP_M    = 2'b11;

    // writable bits of the masked registers
    localparam logic [XLEN-1:0] MTVEC_WMASK         = ~64'h2;
    localparam logic [XLEN-1:0] MEPC_WMASK          = ~64'h3;
    localparam logic [XLEN-1:0] MCOUNTINHIBIT_WMASK = 64'h5;
    localparam int              INHIBIT_CY_BIT      = 0;
    localparam int              INHIBIT_IR_BIT      = 2;

    //////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////

    typedef enum logic [CSR_IDX_W-1:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MISA          = 12'h301,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MTVAL         = 12'h343,
        CSR_MCYCLE        = 12'hB00,
        CSR_MINSTRET      = 12'hB02,
        CSR_MVENDORID     = 12'hF11,
        CSR_MARCHID       = 12'hF12,
        CSR_MIMPID        = 12'hF13,
        CSR_MHARTID       = 12'hF14
    } csr_index_e;

    // major opcodes that matter for the flush decision
    typedef enum logic [OPCODE_W-1:0] {
        OPC_MISCMEM = 7'b0001111,
        OPC_SYSTEM  = 7'b1110011,
        OPC_OTHER   = 7'b0110011
    } commit_opcode_e;

    //////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////

    typedef struct packed {
        logic            valid;
        logic            csren;
        csr_index_e      index;
        logic [XLEN-1:0] data;
        logic            mret;
    } csr_write_t;

    typedef struct packed {
        logic                    valid;
        commit_opcode_e          opcode;
        logic [XLEN-1:0]         pc;
        logic                    trap;
        logic                    trap_async;
        logic [TRAP_CAUSE_W-1:0] trap_cause;
        logic [XLEN-1:0]         trap_value;
    } instr_commit_t;

    // only the interrupt enable pair is kept in mstatus
    typedef struct packed {
        logic mpie;
        logic mie;
    } mstatus_t;

    typedef struct packed {
        mstatus_t        mstatus;
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mscratch;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
    } trap_csrs_t;

    typedef struct packed {
        logic [XLEN-1:0] mcycle;
        logic [XLEN-1:0] minstret;
        logic [XLEN-1:0] mcountinhibit;
    } counter_csrs_t;

    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] newpc;
    } flush_t;

endpackage

//--- csr_trap_unit.sv
module csr_trap_unit (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  csr_pkg::csr_write_t    csr_commit_i,
    input  csr_pkg::instr_commit_t instr_commit_i,
    output csr_pkg::trap_csrs_t    trap_csrs_o,
    output csr_pkg::flush_t        flush_o
);
    import csr_pkg::*;

    //////////////////////////////////////////////////
    // trap registers
    //////////////////////////////////////////////////

    logic            mie_q;
    logic            mpie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mtval_q;

    logic            csr_wr;
    logic            trap_take;
    logic            mret_take;
    logic            fence_take;
    logic [XLEN-1:0] trap_base;
    logic [XLEN-1:0] trap_target;

    assign csr_wr    = csr_commit_i.valid && csr_commit_i.csren;
    assign trap_take = instr_commit_i.valid && instr_commit_i.trap;
    assign mret_take = csr_commit_i.valid && csr_commit_i.mret;

    // fence and system instructions refetch from the next pc
    assign fence_take = instr_commit_i.valid &&
                        ((instr_commit_i.opcode == OPC_MISCMEM) ||
                         (instr_commit_i.opcode == OPC_SYSTEM));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mie_q      <= 1'b0;
            mpie_q     <= 1'b0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else if (trap_take) begin
            // trap entry, any csr write of the faulting commit is dropped
            mepc_q   <= instr_commit_i.pc;
            mcause_q <= {instr_commit_i.trap_async,
                         {(XLEN-TRAP_CAUSE_W-1){1'b0}},
                         instr_commit_i.trap_cause};
            mtval_q  <= instr_commit_i.trap_value;
            mpie_q   <= mie_q;
            mie_q    <= 1'b0;
        end else begin
            if (csr_wr) begin
                case (csr_commit_i.index)
                    CSR_MSTATUS: begin
                        mie_q  <= csr_commit_i.data[MSTATUS_MIE_BIT];
                        mpie_q <= csr_commit_i.data[MSTATUS_MPIE_BIT];
                    end
                    CSR_MTVEC: begin
                        mtvec_q <= csr_commit_i.data & MTVEC_WMASK;
                    end
                    CSR_MSCRATCH: begin
                        mscratch_q <= csr_commit_i.data;
                    end
                    CSR_MEPC: begin
                        mepc_q <= csr_commit_i.data & MEPC_WMASK;
                    end
                    CSR_MCAUSE: begin
                        mcause_q <= csr_commit_i.data;
                    end
                    CSR_MTVAL: begin
                        mtval_q <= csr_commit_i.data;
                    end
                    default: begin
                    end
                endcase
            end
            // mret restores the enable pair
            if (mret_take) begin
                mie_q  <= mpie_q;
                mpie_q <= 1'b1;
            end
        end
    end

    always_comb begin
        trap_csrs_o.mstatus.mie  = mie_q;
        trap_csrs_o.mstatus.mpie = mpie_q;
        trap_csrs_o.mtvec        = mtvec_q;
        trap_csrs_o.mscratch     = mscratch_q;
        trap_csrs_o.mepc         = mepc_q;
        trap_csrs_o.mcause       = mcause_q;
        trap_csrs_o.mtval        = mtval_q;
    end

    //////////////////////////////////////////////////
    // flush decision
    //////////////////////////////////////////////////

    assign trap_base = {mtvec_q[XLEN-1:2], 2'b00};

    // vectored mode only offsets interrupts
    always_comb begin
        if (mtvec_q[0] && instr_commit_i.trap_async) begin
            trap_target = trap_base +
                          {{(XLEN-TRAP_CAUSE_W-2){1'b0}}, instr_commit_i.trap_cause, 2'b00};
        end else begin
            trap_target = trap_base;
        end
    end

    always_comb begin
        flush_o.req = trap_take || mret_take || fence_take;
        if (trap_take) begin
            flush_o.newpc = trap_target;
        end else if (mret_take) begin
            flush_o.newpc = mepc_q;
        end else begin
            flush_o.newpc = instr_commit_i.pc + XLEN'(4);
        end
    end

    // the commit stage never retires a trap together with an mret
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(trap_take && mret_take))
    else $error("trap and mret committed in the same cycle");

endmodule

//--- csr_counters.sv
module csr_counters (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  csr_pkg::csr_write_t    csr_commit_i,
    input  csr_pkg::instr_commit_t instr_commit_i,
    output csr_pkg::counter_csrs_t counter_csrs_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] mcycle_q;
    logic [XLEN-1:0] minstret_q;
    logic [XLEN-1:0] mcountinhibit_q;

    logic csr_wr;
    logic mcycle_wr;
    logic minstret_wr;
    logic inhibit_wr;
    logic minstret_inc;

    assign csr_wr      = csr_commit_i.valid && csr_commit_i.csren;
    assign mcycle_wr   = csr_wr && (csr_commit_i.index == CSR_MCYCLE);
    assign minstret_wr = csr_wr && (csr_commit_i.index == CSR_MINSTRET);
    assign inhibit_wr  = csr_wr && (csr_commit_i.index == CSR_MCOUNTINHIBIT);

    // trapped instructions do not retire
    assign minstret_inc = instr_commit_i.valid && !instr_commit_i.trap &&
                          !mcountinhibit_q[INHIBIT_IR_BIT];

    //////////////////////////////////////////////////
    // counter registers, a write beats the increment
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mcycle_q        <= '0;
            minstret_q      <= '0;
            mcountinhibit_q <= '0;
        end else begin
            if (mcycle_wr) begin
                mcycle_q <= csr_commit_i.data;
            end else if (!mcountinhibit_q[INHIBIT_CY_BIT]) begin
                mcycle_q <= mcycle_q + XLEN'(1);
            end

            if (minstret_wr) begin
                minstret_q <= csr_commit_i.data;
            end else if (minstret_inc) begin
                minstret_q <= minstret_q + XLEN'(1);
            end

            if (inhibit_wr) begin
                mcountinhibit_q <= csr_commit_i.data & MCOUNTINHIBIT_WMASK;
            end
        end
    end

    assign counter_csrs_o.mcycle        = mcycle_q;
    assign counter_csrs_o.minstret      = minstret_q;
    assign counter_csrs_o.mcountinhibit = mcountinhibit_q;

    // mcycle only moves backwards on a write or a wrap
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$past(mcycle_wr) |-> (mcycle_q >= $past(mcycle_q)) || $past(&mcycle_q))
    else $error("mcycle decreased without a write");

endmodule

//--- csr_read_mux.sv
module csr_read_mux (
    input  csr_pkg::csr_index_e     read_index_i,
    input  csr_pkg::trap_csrs_t     trap_csrs_i,
    input  csr_pkg::counter_csrs_t  counter_csrs_i,
    output logic [csr_pkg::XLEN-1:0] read_data_o,
    output logic                    read_illegal_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] mstatus_view;

    // machine mode only, so mpp is tied to m
    always_comb begin
        mstatus_view                                      = '0;
        mstatus_view[MSTATUS_MIE_BIT]                     = trap_csrs_i.mstatus.mie;
        mstatus_view[MSTATUS_MPIE_BIT]                    = trap_csrs_i.mstatus.mpie;
        mstatus_view[MSTATUS_MPP_LSB+1:MSTATUS_MPP_LSB]   = MSTATUS_MPP_M;
    end

    //////////////////////////////////////////////////
    // read select
    //////////////////////////////////////////////////

    always_comb begin
        read_illegal_o = 1'b0;
        case (read_index_i)
            CSR_MSTATUS:       read_data_o = mstatus_view;
            CSR_MISA:          read_data_o = MISA_VALUE;
            CSR_MTVEC:         read_data_o = trap_csrs_i.mtvec;
            CSR_MSCRATCH:      read_data_o = trap_csrs_i.mscratch;
            CSR_MEPC:          read_data_o = trap_csrs_i.mepc;
            CSR_MCAUSE:        read_data_o = trap_csrs_i.mcause;
            CSR_MTVAL:         read_data_o = trap_csrs_i.mtval;
            CSR_MCOUNTINHIBIT: read_data_o = counter_csrs_i.mcountinhibit;
            CSR_MCYCLE:        read_data_o = counter_csrs_i.mcycle;
            CSR_MINSTRET:      read_data_o = counter_csrs_i.minstret;
            CSR_MHARTID:       read_data_o = MHARTID_VALUE;
            CSR_MVENDORID:     read_data_o = MVENDORID_VALUE;
            CSR_MARCHID:       read_data_o = MARCHID_VALUE;
            CSR_MIMPID:        read_data_o = MIMPID_VALUE;
            default: begin
                read_data_o    = '0;
                read_illegal_o = 1'b1;
            end
        endcase
    end

    // pipeline always presents a defined index
    always_comb begin
        assert (!$isunknown(read_index_i))
        else $error("csr read index is unknown");
    end

endmodule

//--- csr_top.sv
module csr_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  csr_pkg::csr_write_t      csr_commit_i,
    input  csr_pkg::instr_commit_t   instr_commit_i,
    input  csr_pkg::csr_index_e      read_index_i,
    output logic [csr_pkg::XLEN-1:0] read_data_o,
    output logic                     read_illegal_o,
    output csr_pkg::flush_t          flush_o
);
    import csr_pkg::*;

    trap_csrs_t    trap_csrs;
    counter_csrs_t counter_csrs;

    //////////////////////////////////////////////////
    // register blocks
    //////////////////////////////////////////////////

    csr_trap_unit u_trap_unit (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .csr_commit_i   (csr_commit_i),
        .instr_commit_i (instr_commit_i),
        .trap_csrs_o    (trap_csrs),
        .flush_o        (flush_o)
    );

    csr_counters u_counters (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .csr_commit_i   (csr_commit_i),
        .instr_commit_i (instr_commit_i),
        .counter_csrs_o (counter_csrs)
    );

    // combinational read port
    csr_read_mux u_read_mux (
        .read_index_i   (read_index_i),
        .trap_csrs_i    (trap_csrs),
        .counter_csrs_i (counter_csrs),
        .read_data_o    (read_data_o),
        .read_illegal_o (read_illegal_o)
    );

endmodule

//--- tb_csr_top.sv
module tb_csr_top;
    timeunit 1ns;
    timeprecision 1ps;
    import csr_pkg::*;

    localparam int TIMEOUT_CYCLES = 400;

    logic            clk_i;
    logic            arst_n_i;
    csr_write_t      csr_commit;
    instr_commit_t   instr_commit;
    csr_index_e      read_index;
    logic [XLEN-1:0] read_data;
    logic            read_illegal;
    flush_t          flush;

    integer          seed = 32'hcb90;
    int              errors = 0;
    int              checks = 0;
    int              cycle_cnt = 0;
    logic [XLEN-1:0] trap_pc;

    csr_top DUT (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .csr_commit_i   (csr_commit),
        .instr_commit_i (instr_commit),
        .read_index_i   (read_index),
        .read_data_o    (read_data),
        .read_illegal_o (read_illegal),
        .flush_o        (flush)
    );

    always #50 clk_i = ~clk_i;

    // watchdog
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("mismatch at %0d ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    function automatic logic [XLEN-1:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic instr_commit_t make_instr(input commit_opcode_e opc,
                                                 input logic [XLEN-1:0] pc,
                                                 input logic trap,
                                                 input logic async,
                                                 input logic [TRAP_CAUSE_W-1:0] cause,
                                                 input logic [XLEN-1:0] tval);
        instr_commit_t ic;
        ic            = '0;
        ic.valid      = 1'b1;
        ic.opcode     = opc;
        ic.pc         = pc;
        ic.trap       = trap;
        ic.trap_async = async;
        ic.trap_cause = cause;
        ic.trap_value = tval;
        return ic;
    endfunction

    task automatic write_csr(input csr_index_e idx, input logic [XLEN-1:0] data);
        csr_write_t w;
        w       = '0;
        w.valid = 1'b1;
        w.csren = 1'b1;
        w.index = idx;
        w.data  = data;
        @(posedge clk_i);
        csr_commit <= w;
        @(posedge clk_i);
        csr_commit <= '0;
    endtask

    // read port is combinational, sample mid cycle
    task automatic read_csr(input csr_index_e idx, output logic [XLEN-1:0] data);
        @(posedge clk_i);
        read_index <= idx;
        @(negedge clk_i);
        data = read_data;
    endtask

    task automatic commit_instr(input instr_commit_t ic, output flush_t fl);
        @(posedge clk_i);
        instr_commit <= ic;
        @(negedge clk_i);
        fl = flush;
        @(posedge clk_i);
        instr_commit <= '0;
    endtask

    task automatic commit_mret(output flush_t fl);
        csr_write_t w;
        w       = '0;
        w.valid = 1'b1;
        w.mret  = 1'b1;
        @(posedge clk_i);
        csr_commit <= w;
        @(negedge clk_i);
        fl = flush;
        @(posedge clk_i);
        csr_commit <= '0;
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        logic [XLEN-1:0] d;
        read_csr(CSR_MSTATUS, d);
        check_value("mstatus", 64'h1800, d);
        read_csr(CSR_MISA, d);
        check_value("misa", MISA_VALUE, d);
        read_csr(CSR_MHARTID, d);
        check_value("mhartid", MHARTID_VALUE, d);
        // 0x7c0 is not implemented
        read_csr(csr_index_e'(12'h7c0), d);
        check_value("read_data_o", '0, d);
        check_value("read_illegal_o", 64'd1, 64'(read_illegal));
        check_value("flush_o.req", '0, 64'(flush.req));
    endtask

    task automatic test_write_masks();
        logic [XLEN-1:0] d;
        logic [XLEN-1:0] v;
        v = rand_word();
        write_csr(CSR_MSCRATCH, v);
        read_csr(CSR_MSCRATCH, d);
        check_value("mscratch", v, d);
        v = rand_word();
        write_csr(CSR_MEPC, v);
        read_csr(CSR_MEPC, d);
        check_value("mepc", v & ~64'h3, d);
        v = rand_word();
        write_csr(CSR_MTVEC, v);
        read_csr(CSR_MTVEC, d);
        check_value("mtvec", v & ~64'h2, d);
        v = rand_word();
        write_csr(CSR_MSTATUS, v);
        read_csr(CSR_MSTATUS, d);
        check_value("mstatus", (v & 64'h88) | 64'h1800, d);
    endtask

    task automatic trap_and_check(input logic async, input logic [TRAP_CAUSE_W-1:0] cause,
                                  input logic [XLEN-1:0] exp_pc);
        logic [XLEN-1:0] d;
        logic [XLEN-1:0] tval;
        flush_t          fl;
        trap_pc = rand_word() & ~64'h3;
        tval    = rand_word();
        // mie set so mpie has something to capture
        write_csr(CSR_MSTATUS, 64'h8);
        commit_instr(make_instr(OPC_OTHER, trap_pc, 1'b1, async, cause, tval), fl);
        check_value("flush_o.req", 64'd1, 64'(fl.req));
        check_value("flush_o.newpc", exp_pc, fl.newpc);
        read_csr(CSR_MEPC, d);
        check_value("mepc", trap_pc, d);
        read_csr(CSR_MCAUSE, d);
        check_value("mcause", {async, 57'd0, cause}, d);
        read_csr(CSR_MTVAL, d);
        check_value("mtval", tval, d);
        read_csr(CSR_MSTATUS, d);
        check_value("mstatus", 64'h1880, d);
    endtask

    task automatic test_trap_entry();
        logic [XLEN-1:0] base;
        base = rand_word() & ~64'hff;
        write_csr(CSR_MTVEC, base);
        trap_and_check(1'b0, 6'd2, base);
        // vectored mode, interrupt cause 7
        write_csr(CSR_MTVEC, base | 64'h1);
        trap_and_check(1'b1, 6'd7, base + 64'd28);
    endtask

    task automatic mret_and_check(input logic prev_mpie);
        logic [XLEN-1:0] d;
        flush_t          fl;
        // mie opposite to mpie so the swap is visible
        write_csr(CSR_MSTATUS, {56'd0, prev_mpie, 3'd0, !prev_mpie, 3'd0});
        commit_mret(fl);
        check_value("flush_o.req", 64'd1, 64'(fl.req));
        check_value("flush_o.newpc", trap_pc, fl.newpc);
        read_csr(CSR_MSTATUS, d);
        check_value("mstatus", 64'h1880 | (64'(prev_mpie) << 3), d);
    endtask

    task automatic test_mret();
        mret_and_check(1'b1);
        mret_and_check(1'b0);
    endtask

    task automatic test_fence_counters();
        logic [XLEN-1:0] c0;
        logic [XLEN-1:0] c1;
        logic [XLEN-1:0] pc;
        flush_t          fl;
        read_csr(CSR_MINSTRET, c0);
        pc = rand_word() & ~64'h3;
        commit_instr(make_instr(OPC_SYSTEM, pc, 1'b0, 1'b0, '0, '0), fl);
        check_value("flush_o.req", 64'd1, 64'(fl.req));
        check_value("flush_o.newpc", pc + 64'd4, fl.newpc);
        pc = rand_word() & ~64'h3;
        commit_instr(make_instr(OPC_MISCMEM, pc, 1'b0, 1'b0, '0, '0), fl);
        check_value("flush_o.req", 64'd1, 64'(fl.req));
        check_value("flush_o.newpc", pc + 64'd4, fl.newpc);
        commit_instr(make_instr(OPC_OTHER, pc, 1'b0, 1'b0, '0, '0), fl);
        check_value("flush_o.req", '0, 64'(fl.req));
        // a trapped commit does not retire
        commit_instr(make_instr(OPC_OTHER, pc, 1'b1, 1'b0, 6'd2, '0), fl);
        read_csr(CSR_MINSTRET, c1);
        check_value("minstret delta", 64'd3, c1 - c0);
        read_csr(CSR_MCYCLE, c0);
        repeat (5) @(negedge clk_i);
        c1 = read_data;
        check_value("mcycle delta", 64'd5, c1 - c0);
        write_csr(CSR_MCOUNTINHIBIT, 64'h1);
        read_csr(CSR_MCYCLE, c0);
        repeat (5) @(negedge clk_i);
        c1 = read_data;
        check_value("mcycle inhibited delta", '0, c1 - c0);
    endtask

    initial begin
        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        csr_commit   = '0;
        instr_commit = '0;
        read_index   = CSR_MSTATUS;
        trap_pc      = '0;
        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
        test_reset_state();
        test_write_masks();
        test_trap_entry();
        test_mret();
        test_fence_counters();
        @(posedge clk_i);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sources.f
csr_pkg.sv
csr_trap_unit.sv
csr_counters.sv
csr_read_mux.sv
csr_top.sv
tb_csr_top.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --assert
TOP       = tb_csr_top
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
